// File: design/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Register and bus widths
`define CSR_XLEN                32
`define CSR_ADDR_W              12
`define CSR_TIME_W              64

// misa: MXL = 1 (RV32), extensions A, I and M
`define CSR_MISA_VALUE          32'h4000_1101

// Machine timer interrupt, interrupt flag plus code 7
`define CSR_MCAUSE_MTI          32'h8000_0007

// Environment call cause is base + current mode
// U gives 8, M gives 11
`define CSR_ECALL_CAUSE_BASE    32'd8

`endif

// File: design/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    // Commands from the requester
    typedef enum logic [2:0] {
        CSR_X,
        CSR_W,
        CSR_S,
        CSR_C,
        CSR_ECALL,
        CSR_MRET
    } csr_cmd_e;

    // Only M and U are implemented
    typedef enum logic [1:0] {
        MODE_USER    = 2'b00,
        MODE_MACHINE = 2'b11
    } priv_mode_e;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_ADDR_TIME      = 12'hc01,
        CSR_ADDR_TIMEH     = 12'hc81,
        CSR_ADDR_MVENDORID = 12'hf11,
        CSR_ADDR_MARCHID   = 12'hf12,
        CSR_ADDR_MIMPID    = 12'hf13,
        CSR_ADDR_MHARTID   = 12'hf14,
        CSR_ADDR_MSTATUS   = 12'h300,
        CSR_ADDR_MISA      = 12'h301,
        CSR_ADDR_MIE       = 12'h304,
        CSR_ADDR_MTVEC     = 12'h305,
        CSR_ADDR_MSCRATCH  = 12'h340,
        CSR_ADDR_MEPC      = 12'h341,
        CSR_ADDR_MCAUSE    = 12'h342,
        CSR_ADDR_MIP       = 12'h344
    } csr_addr_e;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_READ,
        PH_COMMIT,
        PH_ACK
    } csr_phase_e;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_IRQ,
        TRAP_ECALL,
        TRAP_MRET
    } trap_kind_e;

    typedef struct packed {
        csr_cmd_e                cmd;
        logic [`CSR_ADDR_W-1:0]  addr;
        logic [`CSR_XLEN-1:0]    operand;
        logic [`CSR_XLEN-1:0]    pc;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_XLEN-1:0]    rdata;
        logic                    trap_taken;
        logic [`CSR_XLEN-1:0]    trap_vector;
    } csr_resp_t;

    // Register state the trap decision depends on
    typedef struct packed {
        logic                    mie;
        logic                    mpie;
        priv_mode_e              mpp;
        logic                    mtie;
        logic [`CSR_XLEN-1:0]    mtvec;
        logic [`CSR_XLEN-1:0]    mepc;
    } csr_status_t;

    typedef struct packed {
        trap_kind_e              kind;
        logic [`CSR_XLEN-1:0]    cause;
        logic [`CSR_XLEN-1:0]    epc;
        priv_mode_e              old_mode;
    } trap_update_t;

endpackage

// File: design/csr_cmd_port.sv
`timescale 1ns/1ps

module csr_cmd_port (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              req,
    input  csr_pkg::csr_req_t req_data,
    output logic              ack,
    output csr_pkg::csr_req_t op,
    output logic              read_phase,
    output logic              commit
);
    import csr_pkg::*;

    csr_phase_e state;
    csr_phase_e next_state;
    logic       accept;

    // A new command is only taken from idle
    assign accept = (state == PH_IDLE) && req;

    always_comb begin
        next_state = state;
        case (state)
            PH_IDLE: begin
                if (req) begin
                    next_state = PH_READ;
                end
            end
            PH_READ: begin
                next_state = PH_COMMIT;
            end
            PH_COMMIT: begin
                next_state = PH_ACK;
            end
            PH_ACK: begin
                // Hold ack until the requester lets go
                if (!req) begin
                    next_state = PH_IDLE;
                end
            end
            default: begin
                next_state = PH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= PH_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Request is held for the whole transaction
    always_ff @(posedge clk) begin
        if (accept) begin
            op <= req_data;
        end
    end

    assign read_phase = (state == PH_READ);
    assign commit     = (state == PH_COMMIT);
    assign ack        = (state == PH_ACK);

endmodule

// File: design/trap_ctrl.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module trap_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  csr_pkg::csr_req_t       op,
    input  logic                    read_phase,
    input  logic                    commit,
    input  logic [`CSR_TIME_W-1:0]  mtime,
    input  logic [`CSR_TIME_W-1:0]  mtimecmp,
    input  csr_pkg::csr_status_t    status,
    output csr_pkg::priv_mode_e     mode,
    output csr_pkg::trap_update_t   update,
    output logic                    trap_taken,
    output logic [`CSR_XLEN-1:0]    trap_vector,
    output logic                    mtip
);
    import csr_pkg::*;

    logic                 irq_pending;
    logic [`CSR_XLEN-1:0] mtvec_base;
    trap_kind_e           kind_next;
    logic [`CSR_XLEN-1:0] cause_next;
    logic [`CSR_XLEN-1:0] vector_next;

    // Timer comparator, the only place MTIP is formed
    assign mtip = (mtime >= mtimecmp);

    // U mode is always interruptible, M only with MIE set
    assign irq_pending = mtip && status.mtie && ((mode == MODE_USER) || status.mie);

    assign mtvec_base = {status.mtvec[`CSR_XLEN-1:2], 2'b00};

    always_comb begin
        kind_next   = TRAP_NONE;
        cause_next  = '0;
        vector_next = '0;
        if (irq_pending) begin
            kind_next  = TRAP_IRQ;
            cause_next = `CSR_MCAUSE_MTI;
            // Vectored mode adds 4 x cause code, flag bit shifts out
            if (status.mtvec[1:0] == 2'b01) begin
                vector_next = mtvec_base + (`CSR_MCAUSE_MTI << 2);
            end else begin
                vector_next = mtvec_base;
            end
        end else if (op.cmd == CSR_ECALL) begin
            kind_next   = TRAP_ECALL;
            cause_next  = `CSR_ECALL_CAUSE_BASE + {{(`CSR_XLEN-2){1'b0}}, mode};
            // Synchronous exceptions always use the base
            vector_next = mtvec_base;
        end else if (op.cmd == CSR_MRET) begin
            kind_next   = TRAP_MRET;
            vector_next = status.mepc;
        end
    end

    // Decision is frozen at the read phase and held through ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            update.kind     <= TRAP_NONE;
            update.cause    <= '0;
            update.epc      <= '0;
            update.old_mode <= MODE_MACHINE;
            trap_taken      <= 1'b0;
            trap_vector     <= '0;
        end else if (read_phase) begin
            update.kind     <= kind_next;
            update.cause    <= cause_next;
            update.epc      <= op.pc;
            update.old_mode <= mode;
            trap_taken      <= (kind_next != TRAP_NONE);
            trap_vector     <= vector_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode <= MODE_MACHINE;
        end else if (commit) begin
            case (update.kind)
                TRAP_IRQ, TRAP_ECALL: begin
                    mode <= MODE_MACHINE;
                end
                TRAP_MRET: begin
                    mode <= status.mpp;
                end
                default: begin
                    mode <= mode;
                end
            endcase
        end
    end

endmodule

// File: design/csr_file.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  csr_pkg::csr_req_t       op,
    input  logic                    commit,
    input  csr_pkg::priv_mode_e     mode,
    input  csr_pkg::trap_update_t   update,
    input  logic [`CSR_TIME_W-1:0]  mtime,
    input  logic                    mtip,
    output csr_pkg::csr_status_t    status,
    output logic [`CSR_XLEN-1:0]    rdata
);
    import csr_pkg::*;

    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    priv_mode_e           mstatus_mpp;
    logic                 mie_meie;
    logic                 mie_mtie;
    logic                 mie_msie;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;

    logic                 can_access;
    logic                 can_write;
    logic                 cmd_is_rmw;
    logic                 write_en;
    logic [`CSR_XLEN-1:0] old_value;
    logic [`CSR_XLEN-1:0] wdata;

    // Address bits [9:8] give the lowest mode allowed
    assign can_access = (op.addr[9:8] <= mode);
    assign can_write  = can_access && (op.addr[11:10] != 2'b11);
    assign cmd_is_rmw = (op.cmd == CSR_W) || (op.cmd == CSR_S) || (op.cmd == CSR_C);
    assign write_en   = cmd_is_rmw && can_write;

    always_comb begin
        case (op.addr)
            CSR_ADDR_TIME:     old_value = mtime[31:0];
            CSR_ADDR_TIMEH:    old_value = mtime[63:32];
            CSR_ADDR_MSTATUS:  old_value = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie,
                                            3'b0, mstatus_mie, 3'b0};
            CSR_ADDR_MISA:     old_value = `CSR_MISA_VALUE;
            CSR_ADDR_MIE:      old_value = {20'b0, mie_meie, 3'b0, mie_mtie,
                                            3'b0, mie_msie, 3'b0};
            CSR_ADDR_MTVEC:    old_value = mtvec;
            CSR_ADDR_MSCRATCH: old_value = mscratch;
            CSR_ADDR_MEPC:     old_value = mepc;
            CSR_ADDR_MCAUSE:   old_value = mcause;
            CSR_ADDR_MIP:      old_value = {24'b0, mtip, 7'b0};
            // ID registers and unknown addresses
            default:           old_value = '0;
        endcase
    end

    always_comb begin
        case (op.cmd)
            CSR_W:   wdata = op.operand;
            CSR_S:   wdata = old_value | op.operand;
            CSR_C:   wdata = old_value & ~op.operand;
            default: wdata = old_value;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= MODE_MACHINE;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_msie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else if (commit) begin
            case (update.kind)
                TRAP_IRQ, TRAP_ECALL: begin
                    mepc         <= {update.epc[`CSR_XLEN-1:2], 2'b00};
                    mcause       <= update.cause;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mstatus_mpp  <= update.old_mode;
                end
                TRAP_MRET: begin
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                    mstatus_mpp  <= MODE_USER;
                end
                default: begin
                    if (write_en) begin
                        case (op.addr)
                            CSR_ADDR_MSTATUS: begin
                                mstatus_mie  <= wdata[3];
                                mstatus_mpie <= wdata[7];
                                // Unsupported MPP encodings fall back to U
                                mstatus_mpp  <= (wdata[12:11] == 2'b11) ? MODE_MACHINE
                                                                        : MODE_USER;
                            end
                            CSR_ADDR_MIE: begin
                                mie_meie <= wdata[11];
                                mie_mtie <= wdata[7];
                                mie_msie <= wdata[3];
                            end
                            CSR_ADDR_MTVEC:    mtvec    <= wdata;
                            CSR_ADDR_MSCRATCH: mscratch <= wdata;
                            CSR_ADDR_MEPC:     mepc     <= {wdata[`CSR_XLEN-1:2], 2'b00};
                            CSR_ADDR_MCAUSE:   mcause   <= wdata;
                            default: begin
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // Denied accesses and traps return zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (commit) begin
            rdata <= (can_access && (update.kind == TRAP_NONE)) ? old_value : '0;
        end
    end

    assign status.mie   = mstatus_mie;
    assign status.mpie  = mstatus_mpie;
    assign status.mpp   = mstatus_mpp;
    assign status.mtie  = mie_mtie;
    assign status.mtvec = mtvec;
    assign status.mepc  = mepc;

endmodule

// File: design/csr_unit.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req,
    input  csr_pkg::csr_req_t       req_data,
    input  logic [`CSR_TIME_W-1:0]  mtime,
    input  logic [`CSR_TIME_W-1:0]  mtimecmp,
    output logic                    ack,
    output csr_pkg::csr_resp_t      resp
);
    import csr_pkg::*;

    csr_req_t             op;
    logic                 read_phase;
    logic                 commit;
    priv_mode_e           mode;
    trap_update_t         update;
    csr_status_t          status;
    logic                 mtip;
    logic                 trap_taken;
    logic [`CSR_XLEN-1:0] trap_vector;
    logic [`CSR_XLEN-1:0] rdata;

    csr_cmd_port csr_cmd_port_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .req_data   (req_data),
        .ack        (ack),
        .op         (op),
        .read_phase (read_phase),
        .commit     (commit)
    );

    trap_ctrl trap_ctrl_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .op          (op),
        .read_phase  (read_phase),
        .commit      (commit),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .status      (status),
        .mode        (mode),
        .update      (update),
        .trap_taken  (trap_taken),
        .trap_vector (trap_vector),
        .mtip        (mtip)
    );

    csr_file csr_file_i (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (op),
        .commit (commit),
        .mode   (mode),
        .update (update),
        .mtime  (mtime),
        .mtip   (mtip),
        .status (status),
        .rdata  (rdata)
    );

    // Both halves are registered, so resp holds while ack is high
    assign resp.rdata       = rdata;
    assign resp.trap_taken  = trap_taken;
    assign resp.trap_vector = trap_vector;

endmodule

// File: testbench/csr_unit_assertions.sv
`timescale 1ns/1ps

module csr_unit_assertions (
    input logic               clk,
    input logic               arst_n,
    input logic               req,
    input logic               ack,
    input csr_pkg::csr_resp_t resp
);

    // No handshake activity while reset is applied
    ack_low_in_reset: assert property (
        @(posedge clk) !arst_n |-> !ack
    ) else $error("ack is high while reset is asserted");

    // ack only answers a pending request
    ack_rise_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req)
    ) else $error("ack rose without a request");

    // Back-pressure keeps ack up
    ack_held_with_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        (ack && req) |=> ack
    ) else $error("ack dropped while req was still high");

    resp_stable_in_ack: assert property (
        @(posedge clk) disable iff (!arst_n)
        (ack && $past(ack)) |-> $stable(resp)
    ) else $error("resp changed while ack was high");

endmodule

// File: testbench/csr_unit_tb.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam int RANDOM_OPS  = 48;
    localparam int NUM_TXN     = 2 * RANDOM_OPS + 50;
    localparam int CYCLE_LIMIT = NUM_TXN * 8 + 200;
    localparam logic [`CSR_TIME_W-1:0] TIME_MAX = '1;

    logic                   clk;
    logic                   arst_n;
    logic                   req;
    csr_req_t               req_data;
    logic [`CSR_TIME_W-1:0] mtime;
    logic [`CSR_TIME_W-1:0] mtimecmp;
    logic                   ack;
    csr_resp_t              resp;

    logic [31:0]            lfsr;
    logic [`CSR_XLEN-1:0]   pc_next;
    int                     cycles = 0;
    int                     checked = 0;
    csr_resp_t              exp_q[$];
    csr_resp_t              got_q[$];
    logic [`CSR_ADDR_W-1:0] rand_addrs[4] = '{CSR_ADDR_MSCRATCH, CSR_ADDR_MTVEC,
                                              CSR_ADDR_MIE, CSR_ADDR_MCAUSE};

    // Reference model of the kept state
    priv_mode_e             m_mode;
    logic                   m_mie;
    logic                   m_mpie;
    priv_mode_e             m_mpp;
    logic [`CSR_XLEN-1:0]   m_mie_reg;
    logic [`CSR_XLEN-1:0]   m_mtvec;
    logic [`CSR_XLEN-1:0]   m_mscratch;
    logic [`CSR_XLEN-1:0]   m_mepc;
    logic [`CSR_XLEN-1:0]   m_mcause;

    csr_unit csr_unit_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .req_data (req_data),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .ack      (ack),
        .resp     (resp)
    );

    bind csr_unit csr_unit_assertions csr_unit_assertions_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .ack    (ack),
        .resp   (resp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            stop_with_failure("Timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping after the first error");
    endtask

    task automatic compare_resp(input string name, input csr_resp_t got, input csr_resp_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got rdata=%h taken=%h vector=%h, expected rdata=%h taken=%h vector=%h",
                     name, got.rdata, got.trap_taken, got.trap_vector,
                     exp.rdata, exp.trap_taken, exp.trap_vector);
            stop_with_failure("response mismatch");
        end
    endtask

    task automatic compare_word(input string name, input logic [`CSR_XLEN-1:0] got,
                                input logic [`CSR_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            stop_with_failure("read data mismatch");
        end
    endtask

    // Galois LFSR shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [`CSR_XLEN-1:0] model_read(input logic [`CSR_ADDR_W-1:0] a);
        logic [`CSR_XLEN-1:0] word;
        word = '0;
        case (a)
            CSR_ADDR_TIME:     word = mtime[31:0];
            CSR_ADDR_TIMEH:    word = mtime[63:32];
            CSR_ADDR_MSTATUS: begin
                word[3]     = m_mie;
                word[7]     = m_mpie;
                word[12:11] = m_mpp;
            end
            CSR_ADDR_MISA:     word = `CSR_MISA_VALUE;
            CSR_ADDR_MIE:      word = m_mie_reg;
            CSR_ADDR_MTVEC:    word = m_mtvec;
            CSR_ADDR_MSCRATCH: word = m_mscratch;
            CSR_ADDR_MEPC:     word = m_mepc;
            CSR_ADDR_MCAUSE:   word = m_mcause;
            CSR_ADDR_MIP:      word[7] = (mtime >= mtimecmp);
            default:           word = '0;
        endcase
        return word;
    endfunction

    function automatic logic irq_expected();
        return (mtime >= mtimecmp) && m_mie_reg[7] && ((m_mode == MODE_USER) || m_mie);
    endfunction

    function automatic csr_resp_t ref_response(input csr_req_t r);
        csr_resp_t e;
        e = '0;
        if (irq_expected()) begin
            e.trap_taken  = 1'b1;
            e.trap_vector = {m_mtvec[31:2], 2'b00};
            if (m_mtvec[1:0] == 2'b01) begin
                e.trap_vector = e.trap_vector + 32'd28;
            end
        end else if (r.cmd == CSR_ECALL) begin
            e.trap_taken  = 1'b1;
            e.trap_vector = {m_mtvec[31:2], 2'b00};
        end else if (r.cmd == CSR_MRET) begin
            e.trap_taken  = 1'b1;
            e.trap_vector = m_mepc;
        end else if (r.addr[9:8] <= m_mode) begin
            e.rdata = model_read(r.addr);
        end
        return e;
    endfunction

    function automatic void update_model(input csr_req_t r);
        logic                 irq;
        logic [`CSR_XLEN-1:0] old_val;
        logic [`CSR_XLEN-1:0] new_val;
        irq     = irq_expected();
        old_val = model_read(r.addr);
        new_val = (r.cmd == CSR_W) ? r.operand :
                  (r.cmd == CSR_S) ? (old_val | r.operand) : (old_val & ~r.operand);
        if (irq || (r.cmd == CSR_ECALL)) begin
            m_mepc   = {r.pc[31:2], 2'b00};
            m_mcause = irq ? `CSR_MCAUSE_MTI : (`CSR_ECALL_CAUSE_BASE + {30'b0, m_mode});
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_mpp    = m_mode;
            m_mode   = MODE_MACHINE;
        end else if (r.cmd == CSR_MRET) begin
            m_mode = m_mpp;
            m_mie  = m_mpie;
            m_mpie = 1'b1;
            m_mpp  = MODE_USER;
        end else if ((r.cmd == CSR_W || r.cmd == CSR_S || r.cmd == CSR_C) &&
                     (r.addr[9:8] <= m_mode) && (r.addr[11:10] != 2'b11)) begin
            case (r.addr)
                CSR_ADDR_MSTATUS: begin
                    m_mie  = new_val[3];
                    m_mpie = new_val[7];
                    m_mpp  = (new_val[12:11] == 2'b11) ? MODE_MACHINE : MODE_USER;
                end
                CSR_ADDR_MIE:      m_mie_reg  = new_val & 32'h0000_0888;
                CSR_ADDR_MTVEC:    m_mtvec    = new_val;
                CSR_ADDR_MSCRATCH: m_mscratch = new_val;
                CSR_ADDR_MEPC:     m_mepc     = {new_val[31:2], 2'b00};
                CSR_ADDR_MCAUSE:   m_mcause   = new_val;
                default: begin
                end
            endcase
        end
    endfunction

    // Full four-phase transaction
    // ack must come on the third falling edge, req is then held a few cycles
    task automatic transact(input csr_req_t r, output csr_resp_t got);
        int hold;
        @(negedge clk);
        req      = 1'b1;
        req_data = r;
        exp_q.push_back(ref_response(r));
        update_model(r);
        for (int i = 1; i <= 3; i++) begin
            @(negedge clk);
            if (ack !== (i == 3)) begin
                stop_with_failure("ack did not rise exactly 2 cycles after req was sampled");
            end
        end
        got = resp;
        got_q.push_back(resp);
        // Back-pressure keeps the unit waiting in the ack phase
        hold = rand_bits(2);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
                stop_with_failure("ack dropped while req was still held high");
            end
            compare_resp("resp under back-pressure", resp, got);
        end
        req = 1'b0;
        @(negedge clk);
        if (ack !== 1'b0) begin
            stop_with_failure("ack did not fall after req was dropped");
        end
    endtask

    task automatic run_cmd(input csr_cmd_e cmd, input logic [`CSR_ADDR_W-1:0] addr,
                           input logic [`CSR_XLEN-1:0] operand, output csr_resp_t r);
        csr_req_t q;
        q.cmd     = cmd;
        q.addr    = addr;
        q.operand = operand;
        q.pc      = pc_next;
        pc_next   = pc_next + 32'd4;
        transact(q, r);
    endtask

    task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr,
                            output logic [`CSR_XLEN-1:0] word);
        csr_resp_t r;
        run_cmd(CSR_S, addr, '0, r);
        word = r.rdata;
    endtask

    task automatic write_csr(input logic [`CSR_ADDR_W-1:0] addr,
                             input logic [`CSR_XLEN-1:0] value);
        csr_resp_t r;
        run_cmd(CSR_W, addr, value, r);
    endtask

    task automatic check_read(input string name, input logic [`CSR_ADDR_W-1:0] addr,
                              input logic [`CSR_XLEN-1:0] exp);
        logic [`CSR_XLEN-1:0] word;
        read_csr(addr, word);
        compare_word(name, word, exp);
    endtask

    task automatic expect_trap(input string name, input csr_resp_t r,
                               input logic [`CSR_XLEN-1:0] vector);
        csr_resp_t e;
        e.rdata       = '0;
        e.trap_taken  = 1'b1;
        e.trap_vector = vector;
        compare_resp(name, r, e);
    endtask

    task automatic set_timer(input logic [`CSR_TIME_W-1:0] t, input logic [`CSR_TIME_W-1:0] c);
        @(negedge clk);
        mtime    = t;
        mtimecmp = c;
    endtask

    // Compares every response against the reference model
    always @(negedge clk) begin
        while (got_q.size() > 0) begin
            compare_resp($sformatf("resp[%0d]", checked), got_q.pop_front(), exp_q.pop_front());
            checked++;
        end
    end

    initial begin
        csr_resp_t            r;
        csr_cmd_e             cmd;
        logic [31:0]          pick;
        logic [`CSR_XLEN-1:0] saved;
        logic [`CSR_XLEN-1:0] ecall_pc;

        clk      = 1'b0;
        arst_n   = 1'b0;
        req      = 1'b0;
        req_data = '0;
        mtime    = '0;
        mtimecmp = TIME_MAX;
        lfsr     = 32'he5d4a36e;
        pc_next  = 32'h0000_0100;
        m_mode   = MODE_MACHINE;
        m_mpp    = MODE_MACHINE;
        m_mie    = 1'b0;
        m_mpie   = 1'b0;
        m_mie_reg  = '0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        if (ack !== 1'b0) begin
            stop_with_failure("ack is high after reset");
        end

        // Reset values
        check_read("mstatus", CSR_ADDR_MSTATUS, 32'h0000_1800);
        check_read("misa", CSR_ADDR_MISA, `CSR_MISA_VALUE);
        check_read("mtvec", CSR_ADDR_MTVEC, '0);
        check_read("mscratch", CSR_ADDR_MSCRATCH, '0);
        check_read("mepc", CSR_ADDR_MEPC, '0);

        // Random read-modify-write with a read-back after each
        for (int i = 0; i < RANDOM_OPS; i++) begin
            pick = rand_bits(2);
            cmd  = (pick[1:0] == 2'd0) ? CSR_W : (pick[1:0] == 2'd1) ? CSR_S : CSR_C;
            pick = rand_bits(2);
            run_cmd(cmd, rand_addrs[pick[1:0]], rand_bits(32), r);
            read_csr(rand_addrs[pick[1:0]], saved);
        end
        write_csr(CSR_ADDR_MIE, 32'hffff_ffff);
        check_read("mie", CSR_ADDR_MIE, 32'h0000_0888);
        write_csr(CSR_ADDR_MEPC, 32'h1234_567b);
        check_read("mepc", CSR_ADDR_MEPC, 32'h1234_5678);

        // Read-only registers, time and mip
        write_csr(CSR_ADDR_MISA, 32'h0);
        check_read("misa", CSR_ADDR_MISA, `CSR_MISA_VALUE);
        write_csr(CSR_ADDR_MHARTID, 32'h5a5a_5a5a);
        check_read("mhartid", CSR_ADDR_MHARTID, '0);
        write_csr(CSR_ADDR_MIE, '0);
        set_timer({rand_bits(31), rand_bits(32)}, TIME_MAX);
        check_read("time", CSR_ADDR_TIME, mtime[31:0]);
        check_read("timeh", CSR_ADDR_TIMEH, mtime[63:32]);
        check_read("mip", CSR_ADDR_MIP, '0);
        set_timer(mtime, mtime);
        check_read("mip", CSR_ADDR_MIP, 32'h0000_0080);
        set_timer(mtime, TIME_MAX);

        // ECALL and MRET from M mode
        write_csr(CSR_ADDR_MTVEC, 32'h0000_1000);
        write_csr(CSR_ADDR_MSTATUS, 32'h0000_1808);
        ecall_pc = pc_next;
        run_cmd(CSR_ECALL, '0, '0, r);
        expect_trap("ecall resp", r, 32'h0000_1000);
        check_read("mcause", CSR_ADDR_MCAUSE, 32'd11);
        check_read("mepc", CSR_ADDR_MEPC, ecall_pc);
        check_read("mstatus", CSR_ADDR_MSTATUS, 32'h0000_1880);
        saved = 32'h600d_f00d;
        write_csr(CSR_ADDR_MSCRATCH, saved);
        write_csr(CSR_ADDR_MSTATUS, 32'h0000_0080);
        run_cmd(CSR_MRET, '0, '0, r);
        expect_trap("mret resp", r, ecall_pc);

        // User mode cannot reach machine CSRs
        check_read("mscratch in U", CSR_ADDR_MSCRATCH, '0);
        run_cmd(CSR_W, CSR_ADDR_MSCRATCH, 32'hdead_beef, r);
        compare_word("mscratch write in U", r.rdata, '0);
        run_cmd(CSR_ECALL, '0, '0, r);
        expect_trap("ecall from U", r, 32'h0000_1000);
        check_read("mscratch", CSR_ADDR_MSCRATCH, saved);
        check_read("mcause", CSR_ADDR_MCAUSE, 32'd8);
        check_read("mstatus", CSR_ADDR_MSTATUS, 32'h0000_0080);

        // Timer interrupt in direct mode
        write_csr(CSR_ADDR_MIE, 32'h0000_0080);
        write_csr(CSR_ADDR_MSTATUS, 32'h0000_1808);
        set_timer(64'd100, 64'd50);
        run_cmd(CSR_W, CSR_ADDR_MSCRATCH, 32'h0000_0055, r);
        expect_trap("irq direct", r, 32'h0000_1000);
        set_timer(64'd100, TIME_MAX);
        check_read("mcause", CSR_ADDR_MCAUSE, `CSR_MCAUSE_MTI);
        check_read("mscratch", CSR_ADDR_MSCRATCH, saved);
        check_read("mstatus", CSR_ADDR_MSTATUS, 32'h0000_1880);

        // Vectored mode
        write_csr(CSR_ADDR_MTVEC, 32'h0000_1001);
        write_csr(CSR_ADDR_MSTATUS, 32'h0000_1808);
        set_timer(64'd200, 64'd150);
        run_cmd(CSR_X, CSR_ADDR_MTVEC, '0, r);
        expect_trap("irq vectored", r, 32'h0000_101c);
        set_timer(64'd200, TIME_MAX);

        // Interrupt in U mode with MIE clear
        write_csr(CSR_ADDR_MSTATUS, 32'h0000_0000);
        run_cmd(CSR_MRET, '0, '0, r);
        set_timer(64'd300, 64'd300);
        run_cmd(CSR_C, CSR_ADDR_MSCRATCH, 32'hffff_ffff, r);
        expect_trap("irq in U", r, 32'h0000_101c);
        set_timer(64'd300, TIME_MAX);
        check_read("mcause", CSR_ADDR_MCAUSE, `CSR_MCAUSE_MTI);
        check_read("mstatus", CSR_ADDR_MSTATUS, 32'h0000_0000);
        check_read("mscratch", CSR_ADDR_MSCRATCH, saved);

        repeat (2) @(negedge clk);
        if (got_q.size() != 0) begin
            stop_with_failure("some responses were never compared");
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+design
design/csr_pkg.sv
design/csr_cmd_port.sv
design/trap_ctrl.sv
design/csr_file.sv
design/csr_unit.sv
testbench/csr_unit_assertions.sv
testbench/csr_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module csr_unit_tb -o csr_unit_sim \
    && ./obj_dir/csr_unit_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or run did not complete"; exit 1; }
cat sim.log
grep -q "^Simulation passed$" sim.log || exit 1
